//--- hw/tex_pkg.sv
`default_nettype none

package tex_pkg;

    // request geometry
    localparam int num_lanes  = 2;
    localparam int num_texels = 4;
    localparam int req_infow  = 8;

    // scheduler queue
    localparam int queue_size = 2;
    localparam int slot_bits  = $clog2(queue_size);

    // reads per request, flattened texel-major
    localparam int num_reads  = num_texels * num_lanes;
    localparam int idx_bits   = $clog2(num_reads);

    // tag is {slot, texel, lane}
    localparam int mem_tagw   = slot_bits + idx_bits;

    typedef enum logic [1:0] {
        stride_byte = 2'd0,
        stride_half = 2'd1,
        stride_word = 2'd2
    } tex_stride_e;

    typedef enum logic {
        filter_point    = 1'b0,
        filter_bilinear = 1'b1
    } tex_filter_e;

    typedef enum logic [1:0] {
        slot_free  = 2'd0,
        slot_issue = 2'd1,
        slot_wait  = 2'd2,
        slot_done  = 2'd3
    } slot_state_e;

endpackage

`default_nettype wire

//--- hw/tex_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tex_addr_gen (
    input  wire [tex_pkg::num_lanes-1:0]                              req_mask,
    input  wire tex_pkg::tex_filter_e                                 req_filter,
    input  wire [tex_pkg::num_lanes-1:0][31:0]                        req_baseaddr,
    input  wire [tex_pkg::num_lanes-1:0][tex_pkg::num_texels-1:0][31:0] req_addr,
    output wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][29:0] word_addr,
    output wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][1:0]  byte_off,
    output wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0]       texel_mask,
    output wire [tex_pkg::num_texels-1:0]                             dups
);

    import tex_pkg::*;

    logic [num_lanes-1:0][num_texels-1:0][31:0] full_addr;

    // byte address, then word/offset split
    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        for (genvar t = 0; t < num_texels; t++) begin : g_texel
            assign full_addr[l][t] = req_baseaddr[l] + req_addr[l][t];
            assign word_addr[t][l] = full_addr[l][t][31:2];
            assign byte_off[t][l]  = full_addr[l][t][1:0];
        end
    end

    for (genvar t = 0; t < num_texels; t++) begin : g_need
        logic                 texel_used;
        logic [num_lanes-1:0] lane_match;

        // point sampling only reads texel 0
        assign texel_used = (req_filter == filter_bilinear) || (t == 0);

        // inactive lanes never break a match
        for (genvar l = 0; l < num_lanes; l++) begin : g_match
            assign lane_match[l] = (l == 0) || !req_mask[l]
                                 || (req_addr[l][t] == req_addr[0][t]);
        end

        assign dups[t] = req_mask[0] && (&lane_match);

        // lane 0 reads on behalf of the others
        for (genvar l = 0; l < num_lanes; l++) begin : g_mask
            assign texel_mask[t][l] = req_mask[l] && texel_used && (!dups[t] || (l == 0));
        end
    end

endmodule

`default_nettype wire

//--- hw/tex_mem_sched.sv
`timescale 1ns/100ps
`default_nettype none

module tex_mem_sched (
    input  wire                                                       clk,
    input  wire                                                       arst_n,
    input  wire                                                       req_valid,
    input  wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][29:0] word_addr,
    input  wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][1:0]  byte_off,
    input  wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0]       texel_mask,
    input  wire [tex_pkg::num_texels-1:0]                             dups,
    input  wire [tex_pkg::num_lanes-1:0]                              req_mask,
    input  wire tex_pkg::tex_stride_e                                 req_lgstride,
    input  wire [tex_pkg::req_infow-1:0]                              req_info,
    output wire                                                       req_ready,
    output wire                                                       mem_req_valid,
    output wire [29:0]                                                mem_req_addr,
    output wire [tex_pkg::mem_tagw-1:0]                               mem_req_tag,
    input  wire                                                       mem_req_ready,
    input  wire                                                       mem_rsp_valid,
    input  wire [31:0]                                                mem_rsp_data,
    input  wire [tex_pkg::mem_tagw-1:0]                               mem_rsp_tag,
    output wire                                                       mem_rsp_ready,
    output wire                                                       done_valid,
    output wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][31:0] done_data,
    output wire [tex_pkg::num_lanes-1:0]                              done_mask,
    output wire tex_pkg::tex_stride_e                                 done_lgstride,
    output wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][1:0]  done_off,
    output wire [tex_pkg::num_texels-1:0]                             done_dups,
    output wire [tex_pkg::req_infow-1:0]                              done_info,
    input  wire                                                       done_ready
);

    import tex_pkg::*;

    // slot control
    slot_state_e                slot_state [queue_size];
    logic [num_reads-1:0]       slot_pend  [queue_size];
    logic [num_reads-1:0]       slot_outs  [queue_size];
    logic [num_reads-1:0]       pend_nxt   [queue_size];
    logic [num_reads-1:0]       outs_nxt   [queue_size];

    // slot payload
    logic [num_reads-1:0][29:0] slot_addr   [queue_size];
    logic [num_reads-1:0][1:0]  slot_off    [queue_size];
    logic [num_reads-1:0][31:0] slot_data   [queue_size];
    logic [num_texels-1:0]      slot_dups   [queue_size];
    logic [num_lanes-1:0]       slot_mask   [queue_size];
    tex_stride_e                slot_stride [queue_size];
    logic [req_infow-1:0]       slot_info   [queue_size];

    logic [slot_bits-1:0]       alloc_ptr;
    logic [slot_bits-1:0]       rel_ptr;
    logic [slot_bits-1:0]       iss_slot;
    logic [slot_bits-1:0]       rsp_slot;
    logic [idx_bits-1:0]        iss_idx;
    logic [idx_bits-1:0]        rsp_idx;
    logic                       iss_found;

    wire req_fire  = req_valid && req_ready;
    wire mem_fire  = mem_req_valid && mem_req_ready;
    wire done_fire = done_valid && done_ready;

    // free slots are contiguous from alloc_ptr
    assign req_ready = (slot_state[alloc_ptr] == slot_free);

    assign rsp_slot = mem_rsp_tag[mem_tagw-1 -: slot_bits];
    assign rsp_idx  = mem_rsp_tag[idx_bits-1:0];

    // oldest slot with reads left, then lowest texel/lane
    always_comb begin
        logic [slot_bits-1:0] s;
        iss_found = 1'b0;
        iss_slot  = rel_ptr;
        iss_idx   = '0;
        for (int k = 0; k < queue_size; k++) begin
            s = rel_ptr + slot_bits'(k);
            if (!iss_found && slot_state[s] == slot_issue) begin
                iss_found = 1'b1;
                iss_slot  = s;
            end
        end
        for (int i = num_reads - 1; i >= 0; i--) begin
            if (slot_pend[iss_slot][i]) begin
                iss_idx = idx_bits'(i);
            end
        end
    end

    assign mem_req_valid = iss_found;
    assign mem_req_addr  = slot_addr[iss_slot][iss_idx];
    assign mem_req_tag   = {iss_slot, iss_idx};

    // each slot holds room for all of its own reads
    assign mem_rsp_ready = 1'b1;

    always_comb begin
        for (int s = 0; s < queue_size; s++) begin
            pend_nxt[s] = slot_pend[s];
            outs_nxt[s] = slot_outs[s];
            if (mem_fire && iss_slot == slot_bits'(s)) begin
                pend_nxt[s][iss_idx] = 1'b0;
                outs_nxt[s][iss_idx] = 1'b1;
            end
            if (mem_rsp_valid && rsp_slot == slot_bits'(s)) begin
                outs_nxt[s][rsp_idx] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
            for (int s = 0; s < queue_size; s++) begin
                slot_state[s] <= slot_free;
                slot_pend[s]  <= '0;
                slot_outs[s]  <= '0;
            end
        end else begin
            for (int s = 0; s < queue_size; s++) begin
                slot_pend[s] <= pend_nxt[s];
                slot_outs[s] <= outs_nxt[s];
                case (slot_state[s])
                    slot_free: begin
                        if (req_fire && alloc_ptr == slot_bits'(s)) begin
                            slot_pend[s]  <= texel_mask;
                            // empty lane mask skips straight to done
                            slot_state[s] <= (texel_mask == '0) ? slot_done : slot_issue;
                        end
                    end
                    slot_issue, slot_wait: begin
                        if (pend_nxt[s] == '0 && outs_nxt[s] == '0) begin
                            slot_state[s] <= slot_done;
                        end else if (pend_nxt[s] == '0) begin
                            slot_state[s] <= slot_wait;
                        end
                    end
                    default: begin
                        if (done_fire && rel_ptr == slot_bits'(s)) begin
                            slot_state[s] <= slot_free;
                        end
                    end
                endcase
            end
            if (req_fire) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end
            if (done_fire) begin
                rel_ptr <= rel_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            slot_addr[alloc_ptr]   <= word_addr;
            slot_off[alloc_ptr]    <= byte_off;
            slot_dups[alloc_ptr]   <= dups;
            slot_mask[alloc_ptr]   <= req_mask;
            slot_stride[alloc_ptr] <= req_lgstride;
            slot_info[alloc_ptr]   <= req_info;
        end
        if (mem_rsp_valid) begin
            slot_data[rsp_slot][rsp_idx] <= mem_rsp_data;
        end
    end

    // only the oldest slot may complete
    assign done_valid    = (slot_state[rel_ptr] == slot_done);
    assign done_data     = slot_data[rel_ptr];
    assign done_mask     = slot_mask[rel_ptr];
    assign done_lgstride = slot_stride[rel_ptr];
    assign done_off      = slot_off[rel_ptr];
    assign done_dups     = slot_dups[rel_ptr];
    assign done_info     = slot_info[rel_ptr];

endmodule

`default_nettype wire

//--- hw/tex_rsp_format.sv
`timescale 1ns/100ps
`default_nettype none

module tex_rsp_format (
    input  wire                                                       clk,
    input  wire                                                       arst_n,
    input  wire                                                       done_valid,
    input  wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][31:0] done_data,
    input  wire [tex_pkg::num_lanes-1:0]                              done_mask,
    input  wire tex_pkg::tex_stride_e                                 done_lgstride,
    input  wire [tex_pkg::num_texels-1:0][tex_pkg::num_lanes-1:0][1:0]  done_off,
    input  wire [tex_pkg::num_texels-1:0]                             done_dups,
    input  wire [tex_pkg::req_infow-1:0]                              done_info,
    output wire                                                       done_ready,
    output logic                                                      rsp_valid,
    output logic [tex_pkg::num_lanes-1:0]                             rsp_mask,
    output logic [tex_pkg::num_lanes-1:0][tex_pkg::num_texels-1:0][31:0] rsp_data,
    output logic [tex_pkg::req_infow-1:0]                             rsp_info,
    input  wire                                                       rsp_ready
);

    import tex_pkg::*;

    logic [num_lanes-1:0][num_texels-1:0][31:0] fmt_data;

    wire stall = rsp_valid && !rsp_ready;

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        for (genvar t = 0; t < num_texels; t++) begin : g_texel
            logic [31:0] src;
            logic [31:0] sh_half;
            logic [31:0] sh_byte;

            // duplicates were only read by lane 0
            assign src = ((l == 0) || done_dups[t]) ? done_data[t][0] : done_data[t][l];

            assign sh_half = done_off[t][l][1] ? {16'h0, src[31:16]} : src;
            assign sh_byte = done_off[t][l][0] ? {8'h0, sh_half[31:8]} : sh_half;

            always_comb begin
                case (done_lgstride)
                    stride_byte: fmt_data[l][t] = {24'h0, sh_byte[7:0]};
                    stride_half: fmt_data[l][t] = {16'h0, sh_byte[15:0]};
                    default:     fmt_data[l][t] = sh_byte;
                endcase
            end
        end
    end

    assign done_ready = !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (!stall) begin
            rsp_valid <= done_valid;
        end
    end

    // output register holds while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            rsp_mask <= done_mask;
            rsp_data <= fmt_data;
            rsp_info <= done_info;
        end
    end

endmodule

`default_nettype wire

//--- hw/tex_mem_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tex_mem_unit (
    input  wire                                                       clk,
    input  wire                                                       arst_n,
    input  wire                                                       req_valid,
    input  wire [tex_pkg::num_lanes-1:0]                              req_mask,
    input  wire tex_pkg::tex_filter_e                                 req_filter,
    input  wire tex_pkg::tex_stride_e                                 req_lgstride,
    input  wire [tex_pkg::num_lanes-1:0][31:0]                        req_baseaddr,
    input  wire [tex_pkg::num_lanes-1:0][tex_pkg::num_texels-1:0][31:0] req_addr,
    input  wire [tex_pkg::req_infow-1:0]                              req_info,
    output wire                                                       req_ready,
    output wire                                                       mem_req_valid,
    output wire [29:0]                                                mem_req_addr,
    output wire [tex_pkg::mem_tagw-1:0]                               mem_req_tag,
    input  wire                                                       mem_req_ready,
    input  wire                                                       mem_rsp_valid,
    input  wire [31:0]                                                mem_rsp_data,
    input  wire [tex_pkg::mem_tagw-1:0]                               mem_rsp_tag,
    output wire                                                       mem_rsp_ready,
    output wire                                                       rsp_valid,
    output wire [tex_pkg::num_lanes-1:0]                              rsp_mask,
    output wire [tex_pkg::num_lanes-1:0][tex_pkg::num_texels-1:0][31:0] rsp_data,
    output wire [tex_pkg::req_infow-1:0]                              rsp_info,
    input  wire                                                       rsp_ready
);

    import tex_pkg::*;

    wire [num_texels-1:0][num_lanes-1:0][29:0] word_addr;
    wire [num_texels-1:0][num_lanes-1:0][1:0]  byte_off;
    wire [num_texels-1:0][num_lanes-1:0]       texel_mask;
    wire [num_texels-1:0]                      dups;

    wire                                       done_valid;
    wire [num_texels-1:0][num_lanes-1:0][31:0] done_data;
    wire [num_lanes-1:0]                       done_mask;
    tex_stride_e                               done_lgstride;
    wire [num_texels-1:0][num_lanes-1:0][1:0]  done_off;
    wire [num_texels-1:0]                      done_dups;
    wire [req_infow-1:0]                       done_info;
    wire                                       done_ready;

    tex_addr_gen addr_gen (
        .req_mask     (req_mask),
        .req_filter   (req_filter),
        .req_baseaddr (req_baseaddr),
        .req_addr     (req_addr),
        .word_addr    (word_addr),
        .byte_off     (byte_off),
        .texel_mask   (texel_mask),
        .dups         (dups)
    );

    tex_mem_sched mem_sched (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .word_addr     (word_addr),
        .byte_off      (byte_off),
        .texel_mask    (texel_mask),
        .dups          (dups),
        .req_mask      (req_mask),
        .req_lgstride  (req_lgstride),
        .req_info      (req_info),
        .req_ready     (req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .done_valid    (done_valid),
        .done_data     (done_data),
        .done_mask     (done_mask),
        .done_lgstride (done_lgstride),
        .done_off      (done_off),
        .done_dups     (done_dups),
        .done_info     (done_info),
        .done_ready    (done_ready)
    );

    tex_rsp_format rsp_format (
        .clk           (clk),
        .arst_n        (arst_n),
        .done_valid    (done_valid),
        .done_data     (done_data),
        .done_mask     (done_mask),
        .done_lgstride (done_lgstride),
        .done_off      (done_off),
        .done_dups     (done_dups),
        .done_info     (done_info),
        .done_ready    (done_ready),
        .rsp_valid     (rsp_valid),
        .rsp_mask      (rsp_mask),
        .rsp_data      (rsp_data),
        .rsp_info      (rsp_info),
        .rsp_ready     (rsp_ready)
    );

endmodule

`default_nettype wire

//--- dv/tex_mem_data.svh
// word contents depend on every address bit
function automatic logic [31:0] mem_word(input logic [29:0] a);
    return (32'(a) * 32'h9e37_79b1) ^ {a[13:0], a[29:12]};
endfunction

// fibonacci lfsr with taps 32 22 2 1 shifting in at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

//--- dv/tex_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tex_mem_model (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         mem_req_valid,
    input  wire [29:0]                  mem_req_addr,
    input  wire [tex_pkg::mem_tagw-1:0] mem_req_tag,
    output logic                        mem_req_ready,
    output logic                        mem_rsp_valid,
    output logic [31:0]                 mem_rsp_data,
    output logic [tex_pkg::mem_tagw-1:0] mem_rsp_tag,
    input  wire                         mem_rsp_ready,
    output int                          read_count
);

    import tex_pkg::*;

    `include "tex_mem_data.svh"

    logic [31:0]         lfsr;
    int                  cycle;
    logic [mem_tagw-1:0] q_tag [$];
    logic [31:0]         q_data [$];
    int                  q_due [$];

    always @(posedge clk or negedge arst_n) begin
        int lat;
        if (!arst_n) begin
            lfsr          = 32'h3c3a_0007;
            cycle         = 0;
            read_count    <= 0;
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
            mem_rsp_tag   <= '0;
            q_tag.delete();
            q_data.delete();
            q_due.delete();
        end else begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(q_tag.pop_front());
                void'(q_data.pop_front());
                void'(q_due.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                // latency 0 to 3, two bits
                lfsr = lfsr_step(lfsr);
                lat  = int'(lfsr[0]);
                lfsr = lfsr_step(lfsr);
                lat  = lat * 2 + int'(lfsr[0]);
                q_tag.push_back(mem_req_tag);
                q_data.push_back(mem_word(mem_req_addr));
                q_due.push_back(cycle + lat);
                read_count <= read_count + 1;
            end
            lfsr = lfsr_step(lfsr);
            mem_req_ready <= lfsr[0];
            cycle = cycle + 1;
            // oldest first
            if (q_tag.size() > 0 && q_due[0] < cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= q_data[0];
                mem_rsp_tag   <= q_tag[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tex_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tex_mem_tb;

    import tex_pkg::*;

    `include "tex_mem_data.svh"

    typedef logic [num_lanes-1:0][num_texels-1:0][31:0] texels_t;

    localparam int max_rows = 12;

    logic clk;
    logic arst_n;
    logic req_valid;
    logic [num_lanes-1:0] req_mask;
    tex_filter_e req_filter;
    tex_stride_e req_lgstride;
    logic [num_lanes-1:0][31:0] req_baseaddr;
    texels_t req_addr;
    logic [req_infow-1:0] req_info;
    wire req_ready;
    wire mem_req_valid;
    wire [29:0] mem_req_addr;
    wire [mem_tagw-1:0] mem_req_tag;
    wire mem_req_ready;
    wire mem_rsp_valid;
    wire [31:0] mem_rsp_data;
    wire [mem_tagw-1:0] mem_rsp_tag;
    wire mem_rsp_ready;
    wire rsp_valid;
    wire [num_lanes-1:0] rsp_mask;
    texels_t rsp_data;
    wire [req_infow-1:0] rsp_info;
    logic rsp_ready;
    int read_count;

    // stimulus table
    string                row_name   [max_rows];
    logic [num_lanes-1:0] row_mask   [max_rows];
    tex_filter_e          row_filter [max_rows];
    tex_stride_e          row_stride [max_rows];
    logic [31:0]          row_base0  [max_rows];
    logic [31:0]          row_base1  [max_rows];
    logic [31:0]          row_off0   [max_rows];
    logic [31:0]          row_off1   [max_rows];
    logic [7:0]           row_info   [max_rows];
    int                   row_count  [max_rows];
    bit                   row_bp     [max_rows];
    int                   num_rows;

    // expected responses in request order
    texels_t              exp_data [$];
    logic [7:0]           exp_used [$];
    logic [num_lanes-1:0] exp_mask [$];
    logic [7:0]           exp_info [$];

    logic [31:0] lfsr;
    bit          bp_mode;
    int          errors;
    string       cur_name;

    tex_mem_unit uut (.*);

    tex_mem_model mem (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .read_count    (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input string n, input logic [1:0] m, input tex_filter_e f,
                           input tex_stride_e s, input logic [31:0] b0, input logic [31:0] b1,
                           input logic [31:0] o0, input logic [31:0] o1,
                           input logic [7:0] info, input int cnt, input bit bp);
        row_name[num_rows]   = n;
        row_mask[num_rows]   = m;
        row_filter[num_rows] = f;
        row_stride[num_rows] = s;
        row_base0[num_rows]  = b0;
        row_base1[num_rows]  = b1;
        row_off0[num_rows]   = o0;
        row_off1[num_rows]   = o1;
        row_info[num_rows]   = info;
        row_count[num_rows]  = cnt;
        row_bp[num_rows]     = bp;
        num_rows++;
    endtask

    // field at the byte offset zero-extended to the stride
    function automatic logic [31:0] texel_value(input logic [31:0] addr, input tex_stride_e s);
        logic [31:0] w;
        w = mem_word(addr[31:2]) >> {addr[1:0], 3'b000};
        case (s)
            stride_byte: return {24'h0, w[7:0]};
            stride_half: return {16'h0, w[15:0]};
            default:     return w;
        endcase
    endfunction

    task automatic check_idle(input string when);
        if (rsp_valid !== 1'b0 || mem_req_valid !== 1'b0 || req_ready !== 1'b1) begin
            $display("reset: outputs not idle %s", when);
            errors++;
        end
    endtask

    // drive one request of row r and queue what it should return
    task automatic send_request(input int r, input int k, inout int reads);
        texels_t    exp;
        logic [7:0] used;
        logic       dup;
        logic       ok;
        req_mask        = row_mask[r];
        req_filter      = row_filter[r];
        req_lgstride    = row_stride[r];
        req_baseaddr[0] = row_base0[r] + 32'(k * 65);
        req_baseaddr[1] = row_base1[r] + 32'(k * 65);
        req_info        = row_info[r] + 8'(k);
        used = '0;
        exp  = '0;
        for (int t = 0; t < num_texels; t++) begin
            req_addr[0][t] = 32'(row_off0[r][t*8 +: 8]);
            req_addr[1][t] = 32'(row_off1[r][t*8 +: 8]);
        end
        for (int t = 0; t < num_texels; t++) begin
            dup = row_mask[r][0];
            if (row_mask[r][1] && req_addr[1][t] != req_addr[0][t]) begin
                dup = 1'b0;
            end
            if (row_filter[r] == filter_bilinear || t == 0) begin
                for (int l = 0; l < num_lanes; l++) begin
                    if (row_mask[r][l]) begin
                        used[l*num_texels + t] = 1'b1;
                        if (dup) begin
                            exp[l][t] = texel_value(req_baseaddr[0] + req_addr[0][t],
                                                    row_stride[r]);
                        end else begin
                            exp[l][t] = texel_value(req_baseaddr[l] + req_addr[l][t],
                                                    row_stride[r]);
                        end
                        if (!dup || l == 0) begin
                            reads++;
                        end
                    end
                end
            end
        end
        exp_data.push_back(exp);
        exp_used.push_back(used);
        exp_mask.push_back(row_mask[r]);
        exp_info.push_back(req_info);
        req_valid = 1'b1;
        do begin
            #15 ok = req_ready;
            @(posedge clk);
            #2;
        end while (!ok);
        req_valid = 1'b0;
    endtask

    task automatic check_response();
        texels_t    exp;
        logic [7:0] used;
        logic [1:0] m;
        logic [7:0] info;
        if (exp_info.size() == 0) begin
            $display("%s: response arrived with none outstanding", cur_name);
            errors++;
        end else begin
            exp  = exp_data.pop_front();
            used = exp_used.pop_front();
            m    = exp_mask.pop_front();
            info = exp_info.pop_front();
            if (rsp_mask != m) begin
                $display("Error: %s mask expected %b actual %b", cur_name, m, rsp_mask);
                errors++;
            end
            if (rsp_info != info) begin
                $display("Error: %s info expected %h actual %h", cur_name, info, rsp_info);
                errors++;
            end
            for (int l = 0; l < num_lanes; l++) begin
                for (int t = 0; t < num_texels; t++) begin
                    if (used[l*num_texels + t] && rsp_data[l][t] != exp[l][t]) begin
                        $display("Error: %s lane %0d texel %0d expected %h actual %h",
                                 cur_name, l, t, exp[l][t], rsp_data[l][t]);
                        errors++;
                    end
                end
            end
        end
    endtask

    // monitor samples late in the cycle before the handshake edge
    always begin
        @(posedge clk);
        #15;
        if (arst_n && mem_rsp_valid && mem_rsp_ready !== 1'b1) begin
            $display("%s: memory response was not accepted", cur_name);
            errors++;
        end
        if (arst_n && rsp_valid && rsp_ready) begin
            check_response();
        end
    end

    always @(posedge clk) begin
        #2;
        if (bp_mode) begin
            lfsr = lfsr_step(lfsr);
            rsp_ready = lfsr[0];
        end else begin
            rsp_ready = 1'b1;
        end
    end

    initial begin
        wait (num_rows > 0);
        #(num_rows * 200 * 20 + 10 * 20);
        $display("watchdog expired before all responses returned");
        $display("tests failed");
        $finish;
    end

    initial begin
        int reads_before;
        int exp_reads;
        int err_before;
        int passed;
        int failed;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_mask     = '0;
        req_filter   = filter_point;
        req_lgstride = stride_byte;
        req_baseaddr = '0;
        req_addr     = '0;
        req_info     = '0;
        rsp_ready    = 1'b1;
        lfsr         = 32'h3c3a_0007;
        bp_mode      = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        num_rows     = 0;
        add_row("point_byte", 2'b11, filter_point, stride_byte, 32'h100, 32'h200,
                32'h0c08_0400, 32'h1c18_1410, 8'h10, 4, 1'b0);
        add_row("point_half", 2'b11, filter_point, stride_half, 32'h300, 32'h300,
                32'h0c08_0400, 32'h1c18_1410, 8'h20, 4, 1'b0);
        add_row("point_word", 2'b11, filter_point, stride_word, 32'h500, 32'h700,
                32'h0c08_0400, 32'h1c18_1410, 8'h30, 4, 1'b0);
        add_row("bilinear", 2'b11, filter_bilinear, stride_half, 32'h1000, 32'h2000,
                32'h4440_0400, 32'h2a26_0602, 8'h40, 2, 1'b0);
        add_row("dup_bilinear", 2'b11, filter_bilinear, stride_byte, 32'h3000, 32'h3000,
                32'h4541_0501, 32'h4541_0501, 8'h50, 2, 1'b0);
        add_row("dup_point", 2'b11, filter_point, stride_word, 32'h3800, 32'h3800,
                32'h0000_0008, 32'h0000_0008, 8'h60, 1, 1'b0);
        add_row("lane1_only", 2'b10, filter_bilinear, stride_byte, 32'h4000, 32'h4100,
                32'h0c08_0400, 32'h0d09_0501, 8'h70, 2, 1'b0);
        add_row("empty_mask", 2'b00, filter_bilinear, stride_word, 32'h4800, 32'h4900,
                32'h0c08_0400, 32'h0c08_0400, 8'h80, 1, 1'b0);
        add_row("backpressure", 2'b11, filter_bilinear, stride_byte, 32'h5000, 32'h6000,
                32'h8543_2101, 32'h1a2b_3c4d, 8'h90, 6, 1'b1);

        for (int i = 0; i < 10; i++) begin
            #17 check_idle("during reset");
            @(posedge clk);
        end
        #2 arst_n = 1'b1;
        #15 check_idle("on the first cycle after reset");
        @(posedge clk);
        #2;
        if (errors == 0) begin
            $display("reset: ok");
            passed++;
        end else begin
            $display("reset: failed");
            failed++;
        end

        for (int r = 0; r < num_rows; r++) begin
            cur_name     = row_name[r];
            err_before   = errors;
            reads_before = read_count;
            exp_reads    = 0;
            bp_mode      = row_bp[r];
            for (int k = 0; k < row_count[r]; k++) begin
                send_request(r, k, exp_reads);
            end
            while (exp_info.size() != 0) begin
                @(posedge clk);
                #2;
            end
            bp_mode = 1'b0;
            if (read_count - reads_before != exp_reads) begin
                $display("Error: %s reads expected %0d actual %0d", cur_name, exp_reads,
                         read_count - reads_before);
                errors++;
            end
            if (errors == err_before) begin
                $display("%s: ok", cur_name);
                passed++;
            end else begin
                $display("%s: failed", cur_name);
                failed++;
            end
        end

        // a repeated last response would show up here
        repeat (10) @(posedge clk);

        $display("summary: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
hw/tex_pkg.sv
hw/tex_addr_gen.sv
hw/tex_mem_sched.sv
hw/tex_rsp_format.sv
hw/tex_mem_unit.sv
dv/tex_mem_model.sv
dv/tex_mem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the texel fetch testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module tex_mem_tb -Mdir obj_dir &&
./obj_dir/Vtex_mem_tb | tee /dev/stderr | grep -q "all tests passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
